//--- Bender.yml
package:
  name: dmem_ctrl

sources:
  - files:
      - logic/dmem_pkg.sv
      - logic/dmem_membuf.sv
      - logic/dmem_misalign_chk.sv
      - logic/dmem_pma_chk.sv
      - logic/dmem_pmp_chk.sv
      - logic/dmem_bus_ctrl.sv
      - logic/dmem_ctrl.sv
  - target: test
    files:
      - verification/dmem_ctrl_tb.sv

//--- flist.f
logic/dmem_pkg.sv
logic/dmem_membuf.sv
logic/dmem_misalign_chk.sv
logic/dmem_pma_chk.sv
logic/dmem_pmp_chk.sv
logic/dmem_bus_ctrl.sv
logic/dmem_ctrl.sv
verification/dmem_ctrl_tb.sv

//--- logic/dmem_bus_ctrl.sv
/*
 * Bus controller for uncached data accesses
 * Issues BIU transfers or immediate error responses, returns read data
 */
`timescale 1ns/100ps
`default_nettype none

module dmem_bus_ctrl #(
  parameter int XLEN = 32
)
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Buffer head and check results
  input  logic                 q_valid_i,
  input  logic                 q_we_i,
  input  dmem_pkg::dmem_size_t q_size_i,
  input  logic [XLEN-1:0]      q_adr_i,
  input  logic [XLEN-1:0]      q_d_i,
  input  dmem_pkg::dmem_prv_t  q_prv_i,
  input  logic                 misaligned_i,
  input  logic                 pma_fault_i,
  input  logic                 pmp_fault_i,
  output logic                 q_pop_o,

  // CPU response
  output logic [XLEN-1:0]      mem_q_o,
  output logic                 mem_ack_o,
  output logic                 mem_err_o,
  output logic                 mem_misaligned_o,

  // BIU
  output logic                 biu_stb_o,
  input  logic                 biu_stb_ack_i,
  output logic [XLEN-1:0]      biu_adr_o,
  output dmem_pkg::dmem_size_t biu_size_o,
  output logic                 biu_we_o,
  output dmem_pkg::dmem_prot_t biu_prot_o,
  output logic [XLEN-1:0]      biu_d_o,
  input  logic [XLEN-1:0]      biu_q_i,
  input  logic                 biu_ack_i,
  input  logic                 biu_err_i
);
  import dmem_pkg::*;

  bus_state_t state;
  logic       chk_fail;
  logic       bus_done;

  assign chk_fail = misaligned_i | pma_fault_i | pmp_fault_i;

  // Response may come with the strobe ack
  assign bus_done = (biu_ack_i | biu_err_i) &
                    ((state == ST_WAIT) | ((state == ST_STROBE) & biu_stb_ack_i));

  // Head leaves together with its response pulse
  assign q_pop_o = mem_ack_o | mem_err_o;

  //////////////////////////////////////////////////////////////////////
  // FSM and response pulses
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state            <= ST_IDLE;
      mem_ack_o        <= 1'b0;
      mem_err_o        <= 1'b0;
      mem_misaligned_o <= 1'b0;
    end
    else
    begin
      mem_ack_o        <= 1'b0;
      mem_err_o        <= 1'b0;
      mem_misaligned_o <= 1'b0;
      if (bus_done)
      begin
        // Bus error wins over ack
        mem_ack_o <= ~biu_err_i;
        mem_err_o <= biu_err_i;
        state     <= ST_IDLE;
      end
      else
      begin
        case (state)
          // Skip the head that is being popped
          ST_IDLE:
            if (q_valid_i && !q_pop_o)
            begin
              if (chk_fail)
              begin
                mem_err_o        <= 1'b1;
                mem_misaligned_o <= misaligned_i;
              end
              else
                state <= ST_STROBE;
            end
          ST_STROBE:
            if (biu_stb_ack_i)
              state <= ST_WAIT;
          default: ;
        endcase
      end
    end
  end

  // Read data holds between load responses
  always_ff @(posedge clk_i)
  begin
    if (bus_done && biu_ack_i && !biu_err_i && !q_we_i)
      mem_q_o <= biu_q_i;
  end

  // Transfer fields straight from the held head entry
  assign biu_stb_o  = (state == ST_STROBE);
  assign biu_adr_o  = q_adr_i;
  assign biu_size_o = q_size_i;
  assign biu_we_o   = q_we_i;
  assign biu_d_o    = q_d_i;
  assign biu_prot_o = (q_prv_i == PRV_U) ? PROT_DATA_USER : PROT_DATA_PRIV;

endmodule

`default_nettype wire

//--- logic/dmem_ctrl.sv
/*
 * Data memory access block, uncached
 * Request buffer, alignment, PMA and PMP checks, bus controller
 */
`timescale 1ns/100ps
`default_nettype none

module dmem_ctrl #(
  parameter int XLEN    = 32,
  parameter int PMA_CNT = 3,
  parameter int PMP_CNT = 4
)
(
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,

  // Configuration
  input  logic [PMA_CNT-1:0][dmem_pkg::PMA_CFG_W-1:0] pma_cfg_i,
  input  logic [PMA_CNT-1:0][XLEN-1:0]               pma_adr_i,
  input  logic [PMP_CNT-1:0][dmem_pkg::PMP_CFG_W-1:0] pmp_cfg_i,
  input  logic [PMP_CNT-1:0][XLEN-1:0]               pmp_addr_i,
  input  dmem_pkg::dmem_prv_t                         st_prv_i,

  // CPU side
  input  logic                                        mem_req_i,
  input  logic                                        mem_we_i,
  input  dmem_pkg::dmem_size_t                        mem_size_i,
  input  logic [XLEN-1:0]                             mem_adr_i,
  input  logic [XLEN-1:0]                             mem_d_i,
  output logic                                        mem_rdy_o,
  output logic [XLEN-1:0]                             mem_q_o,
  output logic                                        mem_ack_o,
  output logic                                        mem_err_o,
  output logic                                        mem_misaligned_o,

  // BIU
  output logic                                        biu_stb_o,
  output logic [XLEN-1:0]                             biu_adr_o,
  output dmem_pkg::dmem_size_t                        biu_size_o,
  output logic                                        biu_we_o,
  output dmem_pkg::dmem_prot_t                        biu_prot_o,
  output logic [XLEN-1:0]                             biu_d_o,
  input  logic                                        biu_stb_ack_i,
  input  logic [XLEN-1:0]                             biu_q_i,
  input  logic                                        biu_ack_i,
  input  logic                                        biu_err_i
);
  import dmem_pkg::*;

  // Buffer head
  logic            q_valid;
  logic            q_we;
  dmem_size_t      q_size;
  logic [XLEN-1:0] q_adr;
  logic [XLEN-1:0] q_d;
  dmem_prv_t       q_prv;
  logic            q_pop;

  // Check results
  logic            misaligned;
  logic            pma_fault;
  logic            pmp_fault;

  dmem_membuf #(
    .XLEN ( XLEN ) )
  membuf_inst (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .req_i     ( mem_req_i  ),
    .we_i      ( mem_we_i   ),
    .size_i    ( mem_size_i ),
    .adr_i     ( mem_adr_i  ),
    .d_i       ( mem_d_i    ),
    .prv_i     ( st_prv_i   ),
    .rdy_o     ( mem_rdy_o  ),
    .pop_i     ( q_pop      ),
    .q_valid_o ( q_valid    ),
    .q_we_o    ( q_we       ),
    .q_size_o  ( q_size     ),
    .q_adr_o   ( q_adr      ),
    .q_d_o     ( q_d        ),
    .q_prv_o   ( q_prv      ) );

  dmem_misalign_chk #(
    .XLEN ( XLEN ) )
  misalign_inst (
    .q_valid_i    ( q_valid    ),
    .adr_i        ( q_adr      ),
    .size_i       ( q_size     ),
    .misaligned_o ( misaligned ) );

  dmem_pma_chk #(
    .XLEN    ( XLEN    ),
    .PMA_CNT ( PMA_CNT ) )
  pma_inst (
    .pma_cfg_i ( pma_cfg_i ),
    .pma_adr_i ( pma_adr_i ),
    .q_valid_i ( q_valid   ),
    .adr_i     ( q_adr     ),
    .size_i    ( q_size    ),
    .we_i      ( q_we      ),
    .fault_o   ( pma_fault ) );

  dmem_pmp_chk #(
    .XLEN    ( XLEN    ),
    .PMP_CNT ( PMP_CNT ) )
  pmp_inst (
    .pmp_cfg_i  ( pmp_cfg_i  ),
    .pmp_addr_i ( pmp_addr_i ),
    .prv_i      ( q_prv      ),
    .q_valid_i  ( q_valid    ),
    .adr_i      ( q_adr      ),
    .we_i       ( q_we       ),
    .fault_o    ( pmp_fault  ) );

  dmem_bus_ctrl #(
    .XLEN ( XLEN ) )
  bus_ctrl_inst (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .q_valid_i        ( q_valid          ),
    .q_we_i           ( q_we             ),
    .q_size_i         ( q_size           ),
    .q_adr_i          ( q_adr            ),
    .q_d_i            ( q_d              ),
    .q_prv_i          ( q_prv            ),
    .misaligned_i     ( misaligned       ),
    .pma_fault_i      ( pma_fault        ),
    .pmp_fault_i      ( pmp_fault        ),
    .q_pop_o          ( q_pop            ),
    .mem_q_o          ( mem_q_o          ),
    .mem_ack_o        ( mem_ack_o        ),
    .mem_err_o        ( mem_err_o        ),
    .mem_misaligned_o ( mem_misaligned_o ),
    .biu_stb_o        ( biu_stb_o        ),
    .biu_stb_ack_i    ( biu_stb_ack_i    ),
    .biu_adr_o        ( biu_adr_o        ),
    .biu_size_o       ( biu_size_o       ),
    .biu_we_o         ( biu_we_o         ),
    .biu_prot_o       ( biu_prot_o       ),
    .biu_d_o          ( biu_d_o          ),
    .biu_q_i          ( biu_q_i          ),
    .biu_ack_i        ( biu_ack_i        ),
    .biu_err_i        ( biu_err_i        ) );

endmodule

`default_nettype wire

//--- logic/dmem_membuf.sv
/*
 * Two-entry in-order request buffer
 * Sits between the CPU request port and the access checks
 */
`timescale 1ns/100ps
`default_nettype none

module dmem_membuf #(
  parameter int XLEN = 32
)
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // CPU side
  input  logic                 req_i,
  input  logic                 we_i,
  input  dmem_pkg::dmem_size_t size_i,
  input  logic [XLEN-1:0]      adr_i,
  input  logic [XLEN-1:0]      d_i,
  input  dmem_pkg::dmem_prv_t  prv_i,
  output logic                 rdy_o,

  // Head entry
  input  logic                 pop_i,
  output logic                 q_valid_o,
  output logic                 q_we_o,
  output dmem_pkg::dmem_size_t q_size_o,
  output logic [XLEN-1:0]      q_adr_o,
  output logic [XLEN-1:0]      q_d_o,
  output dmem_pkg::dmem_prv_t  q_prv_o
);
  import dmem_pkg::*;

  // Entry storage
  logic            we_q   [2];
  dmem_size_t      size_q [2];
  logic [XLEN-1:0] adr_q  [2];
  logic [XLEN-1:0] d_q    [2];
  dmem_prv_t       prv_q  [2];

  logic            wr_ptr;
  logic            rd_ptr;
  logic [1:0]      cnt;
  logic            push;
  logic            pop;

  // Full buffer still accepts when head leaves this cycle
  assign rdy_o     = (cnt != 2'd2) | pop_i;
  assign q_valid_o = (cnt != 2'd0);
  assign push      = req_i & rdy_o;
  assign pop       = pop_i & q_valid_o;

  // Pointers and fill level
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      cnt    <= 2'd0;
    end
    else
    begin
      if (push)
        wr_ptr <= ~wr_ptr;
      if (pop)
        rd_ptr <= ~rd_ptr;
      cnt <= cnt + {1'b0, push} - {1'b0, pop};
    end
  end

  // Capture request, privilege taken at acceptance
  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      we_q[wr_ptr]   <= we_i;
      size_q[wr_ptr] <= size_i;
      adr_q[wr_ptr]  <= adr_i;
      d_q[wr_ptr]    <= d_i;
      prv_q[wr_ptr]  <= prv_i;
    end
  end

  // Head entry
  assign q_we_o   = we_q[rd_ptr];
  assign q_size_o = size_q[rd_ptr];
  assign q_adr_o  = adr_q[rd_ptr];
  assign q_d_o    = d_q[rd_ptr];
  assign q_prv_o  = prv_q[rd_ptr];

endmodule

`default_nettype wire

//--- logic/dmem_misalign_chk.sv
/*
 * Alignment check on the buffer head
 * Transfer size against the low address bits
 */
`timescale 1ns/100ps
`default_nettype none

module dmem_misalign_chk #(
  parameter int XLEN = 32
)
(
  input  logic                 q_valid_i,
  input  logic [XLEN-1:0]      adr_i,
  input  dmem_pkg::dmem_size_t size_i,
  output logic                 misaligned_o
);
  import dmem_pkg::*;

  logic bad_align;

  // Bytes are always aligned
  always_comb
  begin
    case (size_i)
      SZ_HALF: bad_align = adr_i[0];
      SZ_WORD: bad_align = |adr_i[1:0];
      default: bad_align = 1'b0;
    endcase
  end

  // Only flag a live head entry
  assign misaligned_o = q_valid_i & bad_align;

endmodule

`default_nettype wire

//--- logic/dmem_pkg.sv
/*
 * Shared definitions for the data memory access block
 * Transfer size, privilege, PMA region type, bus protection, bus FSM states
 * Field positions inside PMA configuration words and PMP configuration bytes
 */
`default_nettype none

package dmem_pkg;

  //////////////////////////////////////////////////////////////////////
  // Enumerations
  //////////////////////////////////////////////////////////////////////

  // Transfer size, shared by CPU side and BIU side
  typedef enum logic [1:0] {
    SZ_BYTE = 2'b00,
    SZ_HALF = 2'b01,
    SZ_WORD = 2'b10
  } dmem_size_t;

  // Privilege level, RISC-V mstatus encoding
  typedef enum logic [1:0] {
    PRV_U = 2'b00,
    PRV_M = 2'b11
  } dmem_prv_t;

  // PMA region type
  typedef enum logic [1:0] {
    PMA_EMPTY = 2'b00,
    PMA_MEM   = 2'b01,
    PMA_IO    = 2'b10
  } pma_type_t;

  // BIU protection code for data accesses
  typedef enum logic [1:0] {
    PROT_DATA_USER = 2'b00,
    PROT_DATA_PRIV = 2'b01
  } dmem_prot_t;

  // Bus controller FSM
  typedef enum logic [1:0] {
    ST_IDLE   = 2'b00,
    ST_STROBE = 2'b01,
    ST_WAIT   = 2'b10
  } bus_state_t;

  //////////////////////////////////////////////////////////////////////
  // Configuration field positions
  //////////////////////////////////////////////////////////////////////

  // PMA word: {W, R, type[1:0]}
  localparam int PMA_CFG_W    = 4;
  localparam int PMA_TYPE_LSB = 0;
  localparam int PMA_TYPE_MSB = 1;
  localparam int PMA_R_BIT    = 2;
  localparam int PMA_W_BIT    = 3;

  // PMP byte, RISC-V pmpcfg layout
  localparam int         PMP_CFG_W = 8;
  localparam int         PMP_R_BIT = 0;
  localparam int         PMP_W_BIT = 1;
  localparam int         PMP_A_LSB = 3;
  localparam int         PMP_A_MSB = 4;
  localparam int         PMP_L_BIT = 7;
  // Only top-of-range matching is supported
  localparam logic [1:0] PMP_A_TOR = 2'b01;

endpackage

`default_nettype wire

//--- logic/dmem_pma_chk.sv
/*
 * Physical memory attribute check
 * Top-of-range region lookup, type, permission and IO width rules
 */
`timescale 1ns/100ps
`default_nettype none

module dmem_pma_chk #(
  parameter int XLEN    = 32,
  parameter int PMA_CNT = 3
)
(
  // Region table
  input  logic [PMA_CNT-1:0][dmem_pkg::PMA_CFG_W-1:0] pma_cfg_i,
  input  logic [PMA_CNT-1:0][XLEN-1:0]               pma_adr_i,

  // Buffer head
  input  logic                                        q_valid_i,
  input  logic [XLEN-1:0]                             adr_i,
  input  dmem_pkg::dmem_size_t                        size_i,
  input  logic                                        we_i,

  output logic                                        fault_o
);
  import dmem_pkg::*;

  logic                 hit;
  logic [PMA_CFG_W-1:0] sel_cfg;
  pma_type_t            sel_type;
  logic                 fault;

  // Region k spans previous top up to pma_adr_i[k]
  // Lowest matching region decides
  always_comb
  begin
    logic [XLEN-1:0] lo;
    hit     = 1'b0;
    sel_cfg = '0;
    lo      = '0;
    for (int k = 0; k < PMA_CNT; k++)
    begin
      if (!hit && adr_i >= lo && adr_i < pma_adr_i[k])
      begin
        hit     = 1'b1;
        sel_cfg = pma_cfg_i[k];
      end
      lo = pma_adr_i[k];
    end
  end

  assign sel_type = pma_type_t'(sel_cfg[PMA_TYPE_MSB:PMA_TYPE_LSB]);

  // Unmapped, empty, missing permission, narrow IO access
  always_comb
  begin
    if (!hit)
      fault = 1'b1;
    else if (sel_type == PMA_EMPTY)
      fault = 1'b1;
    else if (we_i ? !sel_cfg[PMA_W_BIT] : !sel_cfg[PMA_R_BIT])
      fault = 1'b1;
    else if (sel_type == PMA_IO && size_i != SZ_WORD)
      fault = 1'b1;
    else
      fault = 1'b0;
  end

  assign fault_o = q_valid_i & fault;

endmodule

`default_nettype wire

//--- logic/dmem_pmp_chk.sv
/*
 * Physical memory protection check
 * Top-of-range entries, privilege and lock rules
 * pmp_addr_i entries are byte addresses
 */
`timescale 1ns/100ps
`default_nettype none

module dmem_pmp_chk #(
  parameter int XLEN    = 32,
  parameter int PMP_CNT = 4
)
(
  // PMP entries
  input  logic [PMP_CNT-1:0][dmem_pkg::PMP_CFG_W-1:0] pmp_cfg_i,
  input  logic [PMP_CNT-1:0][XLEN-1:0]               pmp_addr_i,

  // Privilege captured with the request
  input  dmem_pkg::dmem_prv_t                         prv_i,

  // Buffer head
  input  logic                                        q_valid_i,
  input  logic [XLEN-1:0]                             adr_i,
  input  logic                                        we_i,

  output logic                                        fault_o
);
  import dmem_pkg::*;

  logic                 hit;
  logic [PMP_CFG_W-1:0] sel_cfg;
  logic                 perm_ok;
  logic                 fault;

  //////////////////////////////////////////////////////////////////////
  // Entry match
  //////////////////////////////////////////////////////////////////////

  // Lower bound is always the previous pmpaddr, whatever its mode
  // Entries not in TOR mode never match
  always_comb
  begin
    logic [XLEN-1:0] lo;
    hit     = 1'b0;
    sel_cfg = '0;
    lo      = '0;
    for (int i = 0; i < PMP_CNT; i++)
    begin
      if (!hit && pmp_cfg_i[i][PMP_A_MSB:PMP_A_LSB] == PMP_A_TOR &&
          adr_i >= lo && adr_i < pmp_addr_i[i])
      begin
        hit     = 1'b1;
        sel_cfg = pmp_cfg_i[i];
      end
      lo = pmp_addr_i[i];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Privilege and lock rules
  //////////////////////////////////////////////////////////////////////

  // R for loads, W for stores
  assign perm_ok = we_i ? sel_cfg[PMP_W_BIT] : sel_cfg[PMP_R_BIT];

  always_comb
  begin
    // Machine mode only bound by locked entries
    if (prv_i == PRV_M)
      fault = hit & sel_cfg[PMP_L_BIT] & ~perm_ok;
    // User mode needs a matching entry with permission
    else
      fault = ~hit | ~perm_ok;
  end

  assign fault_o = q_valid_i & fault;

endmodule

`default_nettype wire

//--- verification/dmem_ctrl_tb.sv
/*
 * Testbench for the uncached data memory access block
 * Clock, reset, BIU memory model with random handshake delays
 * Stimulus and expected responses read from the test file, in-order checks
 */
`timescale 1ns/100ps
`default_nettype none

module dmem_ctrl_tb;
  import dmem_pkg::*;

  localparam int XLEN         = 32;
  localparam int PMA_CNT      = 3;
  localparam int PMP_CNT      = 4;
  localparam int CLK_PERIOD   = 20;
  localparam int DRIVE_DLY    = 2;
  localparam int SAMPLE_DLY   = 1;
  localparam int MAX_TESTS    = 64;
  localparam int MEM_WORDS    = 4096;
  localparam int RDY_TIMEOUT  = 100;
  localparam int RESP_TIMEOUT = 100;

  logic                                clk_i;
  logic                                rst_n_i;
  logic [PMA_CNT-1:0][PMA_CFG_W-1:0]   pma_cfg_i;
  logic [PMA_CNT-1:0][XLEN-1:0]        pma_adr_i;
  logic [PMP_CNT-1:0][PMP_CFG_W-1:0]   pmp_cfg_i;
  logic [PMP_CNT-1:0][XLEN-1:0]        pmp_addr_i;
  dmem_prv_t                           st_prv_i;
  logic                                mem_req_i;
  logic                                mem_we_i;
  dmem_size_t                          mem_size_i;
  logic [XLEN-1:0]                     mem_adr_i;
  logic [XLEN-1:0]                     mem_d_i;
  logic                                mem_rdy_o;
  logic [XLEN-1:0]                     mem_q_o;
  logic                                mem_ack_o;
  logic                                mem_err_o;
  logic                                mem_misaligned_o;
  logic                                biu_stb_o;
  logic [XLEN-1:0]                     biu_adr_o;
  dmem_size_t                          biu_size_o;
  logic                                biu_we_o;
  dmem_prot_t                          biu_prot_o;
  logic [XLEN-1:0]                     biu_d_o;
  logic                                biu_stb_ack_i;
  logic [XLEN-1:0]                     biu_q_i;
  logic                                biu_ack_i;
  logic                                biu_err_i;

  // Test table, one row per file line
  reg   [8*24-1:0] t_name  [MAX_TESTS];
  logic            t_we    [MAX_TESTS];
  dmem_prv_t       t_prv   [MAX_TESTS];
  dmem_size_t      t_size  [MAX_TESTS];
  logic [31:0]     t_adr   [MAX_TESTS];
  logic [31:0]     t_wdata [MAX_TESTS];
  int              t_exp   [MAX_TESTS];
  logic [31:0]     t_rdata [MAX_TESTS];
  int              n_tests;

  logic [31:0]     mem [MEM_WORDS];
  logic [31:0]     rng_state;
  dmem_prot_t      bus_prot;
  int              pass_cnt;
  int              fail_cnt;
  int              model_err_cnt;
  logic            load_ok;
  logic            timed_out;
  int              di;
  int              ci;
  int              rdy_wait;
  int              resp_wait;

  dmem_ctrl #(.XLEN(XLEN), .PMA_CNT(PMA_CNT), .PMP_CNT(PMP_CNT)) dut (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .pma_cfg_i(pma_cfg_i), .pma_adr_i(pma_adr_i),
    .pmp_cfg_i(pmp_cfg_i), .pmp_addr_i(pmp_addr_i), .st_prv_i(st_prv_i),
    .mem_req_i(mem_req_i), .mem_we_i(mem_we_i), .mem_size_i(mem_size_i),
    .mem_adr_i(mem_adr_i), .mem_d_i(mem_d_i), .mem_rdy_o(mem_rdy_o),
    .mem_q_o(mem_q_o), .mem_ack_o(mem_ack_o), .mem_err_o(mem_err_o),
    .mem_misaligned_o(mem_misaligned_o),
    .biu_stb_o(biu_stb_o), .biu_adr_o(biu_adr_o), .biu_size_o(biu_size_o),
    .biu_we_o(biu_we_o), .biu_prot_o(biu_prot_o), .biu_d_o(biu_d_o),
    .biu_stb_ack_i(biu_stb_ack_i), .biu_q_i(biu_q_i),
    .biu_ack_i(biu_ack_i), .biu_err_i(biu_err_i)
  );

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Halves on even, words on 4-byte boundaries
  function automatic logic is_aligned(input dmem_size_t sz, input logic [31:0] adr);
    if (sz == SZ_HALF)
      return !adr[0];
    if (sz == SZ_WORD)
      return adr[1:0] == 2'b00;
    return 1'b1;
  endfunction

  function automatic logic [23:0] outcome_name(input int code);
    if (code == 0)
      return "ack";
    if (code == 1)
      return "err";
    return "mis";
  endfunction

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // BIU memory model
  //////////////////////////////////////////////////////////////////////

  // Strobe ack after 0..3 cycles, response 0..3 cycles after that
  initial
  begin : bus_model
    int phase;
    int stb_wait;
    int ack_wait;
    phase         = 0;
    stb_wait      = 0;
    ack_wait      = 0;
    rng_state     = 32'd23;
    bus_prot      = PROT_DATA_USER;
    biu_stb_ack_i = 1'b0;
    biu_ack_i     = 1'b0;
    biu_err_i     = 1'b0;
    biu_q_i       = '0;
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = 32'hA500_0000 | (i << 2);
    forever
    begin
      @(posedge clk_i);
      #DRIVE_DLY;
      biu_stb_ack_i = 1'b0;
      biu_ack_i     = 1'b0;
      biu_err_i     = 1'b0;
      if (!rst_n_i)
        phase = 0;
      if (phase == 0 && biu_stb_o)
      begin
        assert (is_aligned(biu_size_o, biu_adr_o) && biu_adr_o < 32'h3000)
        else
        begin
          $display("bus strobe for a request that should have been stopped, adr %h",
                   biu_adr_o);
          model_err_cnt++;
        end
        // Protection of the transfer now on the bus
        bus_prot  = biu_prot_o;
        rng_state = xorshift32(rng_state);
        stb_wait  = int'(rng_state[1:0]);
        ack_wait  = int'(rng_state[5:4]);
        phase     = 1;
      end
      if (phase == 1)
      begin
        if (stb_wait == 0)
        begin
          biu_stb_ack_i = 1'b1;
          phase         = 2;
        end
        else
          stb_wait--;
      end
      // Address and data held by the DUT until the response
      if (phase == 2)
      begin
        if (ack_wait == 0)
        begin
          if (biu_adr_o >= 32'h2800)
            biu_err_i = 1'b1;
          else
          begin
            if (biu_we_o)
              mem[biu_adr_o[13:2]] = biu_d_o;
            biu_q_i   = mem[biu_adr_o[13:2]];
            biu_ack_i = 1'b1;
          end
          phase = 0;
        end
        else
          ack_wait--;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test file and checks
  //////////////////////////////////////////////////////////////////////

  task automatic load_tests;
    int             fd;
    int             rc;
    logic           done;
    reg [8*24-1:0]  tok;
    reg [8*24-1:0]  op;
    reg [8*24-1:0]  prv;
    reg [8*24-1:0]  sz;
    reg [8*24-1:0]  outc;
    logic [31:0]    adr;
    logic [31:0]    wd;
    logic [31:0]    rd;
    reg [8*128-1:0] skip_line;
    n_tests = 0;
    load_ok = 1'b1;
    done    = 1'b0;
    fd      = $fopen("verification/dmem_tests.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open verification/dmem_tests.txt");
      load_ok = 1'b0;
      done    = 1'b1;
    end
    while (!done)
    begin
      rc = $fscanf(fd, "%s", tok);
      if (rc != 1)
        done = 1'b1;
      else if (tok == "#")
        rc = $fgets(skip_line, fd);
      else
      begin
        rc = $fscanf(fd, " %s %s %s %h %h %s %h", op, prv, sz, adr, wd, outc, rd);
        if (rc != 7 || n_tests >= MAX_TESTS)
        begin
          $display("test file line for %0s is malformed or the table is full", tok);
          load_ok = 1'b0;
          done    = 1'b1;
        end
        else
        begin
          t_name[n_tests]  = tok;
          t_we[n_tests]    = (op == "st");
          t_prv[n_tests]   = (prv == "U") ? PRV_U : PRV_M;
          t_size[n_tests]  = (sz == "b") ? SZ_BYTE : ((sz == "h") ? SZ_HALF : SZ_WORD);
          t_adr[n_tests]   = adr;
          t_wdata[n_tests] = wd;
          t_exp[n_tests]   = (outc == "ack") ? 0 : ((outc == "mis") ? 2 : 1);
          t_rdata[n_tests] = rd;
          n_tests++;
        end
      end
    end
    if (fd != 0)
      $fclose(fd);
    if (n_tests == 0)
      load_ok = 1'b0;
  endtask

  task automatic check_reset_state;
    logic ok;
    ok = 1'b1;
    assert (!mem_ack_o && !mem_err_o && !biu_stb_o && mem_rdy_o)
    else
    begin
      $display("ERROR reset_state ack/err/stb/rdy expected 0001 actual %b%b%b%b",
               mem_ack_o, mem_err_o, biu_stb_o, mem_rdy_o);
      ok = 1'b0;
    end
    if (ok)
      pass_cnt++;
    else
      fail_cnt++;
    $display("test reset_state: %0s", ok ? "ok" : "failed");
  endtask

  // Outcome code 0 ack, 1 error, 2 misaligned error
  task automatic check_response(input int k);
    int         got;
    logic       ok;
    dmem_prot_t exp_prot;
    ok  = 1'b1;
    got = mem_ack_o ? 0 : (mem_misaligned_o ? 2 : 1);
    assert (!(mem_ack_o && (mem_err_o || mem_misaligned_o)))
    else
    begin
      $display("ack and error flags high together in test %0s", t_name[k]);
      ok = 1'b0;
    end
    assert (got == t_exp[k])
    else
    begin
      $display("ERROR %0s outcome expected %0s actual %0s", t_name[k],
               outcome_name(t_exp[k]), outcome_name(got));
      ok = 1'b0;
    end
    // Machine mode requests go out privileged
    if (got == 0 && t_exp[k] == 0)
    begin
      exp_prot = (t_prv[k] == PRV_M) ? PROT_DATA_PRIV : PROT_DATA_USER;
      assert (bus_prot == exp_prot)
      else
      begin
        $display("ERROR %0s bus protection expected %0d actual %0d", t_name[k],
                 exp_prot, bus_prot);
        ok = 1'b0;
      end
    end
    if (got == 0 && t_exp[k] == 0 && !t_we[k])
    begin
      assert (mem_q_o == t_rdata[k])
      else
      begin
        $display("ERROR %0s read data expected %h actual %h", t_name[k],
                 t_rdata[k], mem_q_o);
        ok = 1'b0;
      end
    end
    if (ok)
      pass_cnt++;
    else
      fail_cnt++;
    $display("test %0s: %0s", t_name[k], ok ? "ok" : "failed");
  endtask

  initial
  begin
    pass_cnt      = 0;
    fail_cnt      = 0;
    model_err_cnt = 0;
    timed_out     = 1'b0;
    rst_n_i       = 1'b0;
    mem_req_i     = 1'b0;
    mem_we_i      = 1'b0;
    mem_size_i    = SZ_WORD;
    mem_adr_i     = '0;
    mem_d_i       = '0;
    st_prv_i      = PRV_M;
    // PMA word {W, R, type}
    pma_cfg_i[0]  = {1'b1, 1'b1, PMA_MEM};
    pma_cfg_i[1]  = {1'b0, 1'b1, PMA_MEM};
    pma_cfg_i[2]  = {1'b1, 1'b1, PMA_IO};
    pma_adr_i[0]  = 32'h0000_1000;
    pma_adr_i[1]  = 32'h0000_2000;
    pma_adr_i[2]  = 32'h0000_3000;
    // PMP byte {L, 00, A, X, W, R} with A set to TOR
    pmp_cfg_i[0]  = 8'h0B;
    pmp_cfg_i[1]  = 8'h89;
    pmp_cfg_i[2]  = 8'h0B;
    pmp_cfg_i[3]  = 8'h00;
    pmp_addr_i[0] = 32'h0000_0800;
    pmp_addr_i[1] = 32'h0000_1000;
    pmp_addr_i[2] = 32'h0000_3000;
    pmp_addr_i[3] = 32'h0000_0000;
    load_tests();
    repeat (4) @(posedge clk_i);
    #DRIVE_DLY;
    rst_n_i = 1'b1;
    check_reset_state();
    if (load_ok)
    begin
      fork
        // Requests back to back as far as mem_rdy_o allows
        begin
          for (di = 0; di < n_tests && !timed_out; di++)
          begin
            mem_req_i  = 1'b1;
            mem_we_i   = t_we[di];
            mem_size_i = t_size[di];
            mem_adr_i  = t_adr[di];
            mem_d_i    = t_wdata[di];
            st_prv_i   = t_prv[di];
            rdy_wait   = 0;
            while (!mem_rdy_o && rdy_wait < RDY_TIMEOUT && !timed_out)
            begin
              @(posedge clk_i);
              #DRIVE_DLY;
              rdy_wait++;
            end
            if (mem_rdy_o)
            begin
              @(posedge clk_i);
              #DRIVE_DLY;
            end
            else if (!timed_out)
            begin
              $display("timeout: mem_rdy_o stayed low for test %0s", t_name[di]);
              timed_out = 1'b1;
            end
          end
          mem_req_i = 1'b0;
        end
        // Responses in request order
        begin
          for (ci = 0; ci < n_tests && !timed_out; ci++)
          begin
            @(posedge clk_i);
            #SAMPLE_DLY;
            resp_wait = 0;
            while (!mem_ack_o && !mem_err_o && resp_wait < RESP_TIMEOUT && !timed_out)
            begin
              @(posedge clk_i);
              #SAMPLE_DLY;
              resp_wait++;
            end
            if (mem_ack_o || mem_err_o)
              check_response(ci);
            else if (!timed_out)
            begin
              $display("timeout: no response for test %0s", t_name[ci]);
              timed_out = 1'b1;
            end
          end
        end
      join
    end
    $display("tests: %0d run, %0d passed, %0d failed, %0d bus model errors",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, model_err_cnt);
    if (load_ok && !timed_out && fail_cnt == 0 && model_err_cnt == 0 &&
        pass_cnt == n_tests + 1)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/dmem_tests.txt
# name op(st/ld) prv(M/U) size(b/h/w) adr_hex wdata_hex outcome(ack/err/mis) rdata_hex
# Unwritten words read back as a5000000 or-ed with the byte address
st_word_r0      st M w 00000100 12345678 ack 00000000
ld_word_r0      ld M w 00000100 00000000 ack 12345678
ld_fill_r0      ld M w 00000040 00000000 ack a5000040
st_byte_r0      st M b 00000201 000000ee ack 00000000
ld_half_r0      ld M h 00000202 00000000 ack 000000ee
st_word_top     st M w 000007fc 0badf00d ack 00000000
ld_word_top     ld M w 000007fc 00000000 ack 0badf00d
mis_half        ld M h 00000101 00000000 mis 00000000
mis_word        st M w 00000102 aaaaaaaa mis 00000000
mis_word_user   ld U w 00000103 00000000 mis 00000000
pma_ro_store    st M w 00001800 55555555 err 00000000
ld_ro_r1        ld M w 00001800 00000000 ack a5001800
pma_unmapped    ld M w 00003400 00000000 err 00000000
pma_io_byte     ld M b 00002400 00000000 err 00000000
pmp_m_locked_st st M w 00000900 66666666 err 00000000
pmp_m_locked_ld ld M w 00000900 00000000 ack a5000900
pmp_u_st_ok     st U w 00000100 cafef00d ack 00000000
pmp_u_ld_ok     ld U w 00000100 00000000 ack cafef00d
pmp_u_st_locked st U w 00000900 77777777 err 00000000
pmp_u_ld_r1     ld U w 00001800 00000000 ack a5001800
io_st_word      st M w 00002400 11223344 ack 00000000
io_ld_word      ld M w 00002400 00000000 ack 11223344
bus_err_ld      ld M w 00002800 00000000 err 00000000
bus_err_st_user st U w 00002c00 88888888 err 00000000
